/* logic/ccu_defines.svh */
// Sizing macros only; CCU_NUM_PE must equal 2**CCU_PE_ID_W and CCU_CFG_W leaves 11 payload bits
`ifndef CCU_DEFINES_SVH
`define CCU_DEFINES_SVH

// ====================
// PE array
// ====================

// Number of processing elements
`define CCU_NUM_PE 16

// Bits needed to address one PE
`define CCU_PE_ID_W 4

// ====================
// Configuration path
// ====================

// FIFO depth is 2**CCU_FIFO_AW words
`define CCU_FIFO_AW 4

// Host configuration word of kind bit plus PE id plus payload
`define CCU_CFG_W 16

// Accumulator and result value width
`define CCU_ACC_W 16

`endif

/* logic/ccu_cfg_pkg.sv */
// Config word layout fixed as kind in MSB, pe_id below it, payload in the low bits of both views
`include "ccu_defines.svh"

package ccu_cfg_pkg;

    // Payload bits left after kind and PE index
    localparam int CFG_PAYLOAD_W = `CCU_CFG_W - 1 - `CCU_PE_ID_W;

    // Word kind selects which view of the union applies
    typedef enum logic {
        SETUP = 1'b0,
        SEED  = 1'b1
    } cfg_kind_e;

    // Setup view carries the cycle count
    typedef struct packed {
        cfg_kind_e                  kind;
        logic [`CCU_PE_ID_W-1:0]    pe_id;
        logic [CFG_PAYLOAD_W-1:0]   count;
    } cfg_setup_t;

    // Seed view carries the value to accumulate
    typedef struct packed {
        cfg_kind_e                  kind;
        logic [`CCU_PE_ID_W-1:0]    pe_id;
        logic [CFG_PAYLOAD_W-1:0]   seed;
    } cfg_seed_t;

    // One host word decoded by its kind bit
    typedef union packed {
        cfg_setup_t setup;
        cfg_seed_t  seed;
    } cfg_word_u;

endpackage

/* logic/ccu_pe_pkg.sv */
// PE command is a single broadcast word; result id and value widths follow the defines header
`include "ccu_defines.svh"

package ccu_pe_pkg;

    // ====================
    // Controller to PEs
    // ====================

    // Registered command seen by every PE once per cycle
    typedef struct packed {
        logic                                   valid;
        ccu_cfg_pkg::cfg_kind_e                 kind;
        logic [`CCU_PE_ID_W-1:0]                pe_id;
        logic [ccu_cfg_pkg::CFG_PAYLOAD_W-1:0]  payload;
    } pe_cmd_t;

    // ====================
    // Collector to host
    // ====================

    // One serialized result
    typedef struct packed {
        logic [`CCU_PE_ID_W-1:0]    pe_id;
        logic [`CCU_ACC_W-1:0]      value;
    } pe_result_t;

endpackage

/* logic/cfg_fifo.sv */
// First-word fall-through FIFO; pushes while full are dropped, pops while empty are illegal
`timescale 1ns/1ns
`include "ccu_defines.svh"

module cfg_fifo #(
    parameter int ADDR_WIDTH = `CCU_FIFO_AW
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    push,
    input  logic                    pop,
    input  ccu_cfg_pkg::cfg_word_u  data_in,
    output ccu_cfg_pkg::cfg_word_u  data_out,
    output logic                    empty,
    output logic                    full
);
    import ccu_cfg_pkg::*;

    localparam int DEPTH = 1 << ADDR_WIDTH;

    // Word storage
    cfg_word_u mem [DEPTH];

    logic [ADDR_WIDTH-1:0] wr_ptr;
    logic [ADDR_WIDTH-1:0] rd_ptr;
    // One extra bit so a full buffer is distinct from empty
    logic [ADDR_WIDTH:0]   count;

    logic push_ok;
    logic pop_ok;

    // Qualified strobes
    assign push_ok = push && !full;
    assign pop_ok  = pop && !empty;

    // Flags straight from occupancy
    assign empty = (count == '0);
    assign full  = (count == (ADDR_WIDTH + 1)'(DEPTH));

    // Head of queue is always visible
    assign data_out = mem[rd_ptr];

    // ====================
    // Write port
    // ====================
    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= data_in;
        end
    end

    // ====================
    // Pointers and fill
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves fill unchanged
            if (push_ok && !pop_ok) begin
                count <= count + 1'b1;
            end else if (pop_ok && !push_ok) begin
                count <= count - 1'b1;
            end
        end
    end

    // Host ignored cfg_rdy so the word is lost
    a_push_full : assert property (@(posedge clk) disable iff (!rst_n) push |-> !full)
        else $warning("cfg_fifo: push while full dropped");

    // Controller must watch the empty flag
    a_pop_empty : assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty)
        else $error("cfg_fifo: pop while empty");

endmodule

/* logic/ccu.sv */
// Controller FSM; start is honoured only in IDLE and the FIFO is drained fully before go
`timescale 1ns/1ns

module ccu (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  logic                    fifo_empty,
    input  ccu_cfg_pkg::cfg_word_u  fifo_out,
    output logic                    fifo_pop,
    output ccu_pe_pkg::pe_cmd_t     pe_cmd,
    output logic                    go,
    input  logic                    all_finish,
    output logic                    busy
);
    import ccu_cfg_pkg::*;
    import ccu_pe_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        CFG,
        CMP
    } state_e;

    state_e  state;
    state_e  next_state;
    // Decoded command before the output register
    pe_cmd_t cmd_d;

    // ====================
    // FSM
    // ====================
    always_comb begin
        next_state = state;
        case (state)
            // Wait for the host
            IDLE: begin
                if (start) begin
                    next_state = CFG;
                end
            end
            // Drain until nothing is left
            CFG: begin
                if (fifo_empty) begin
                    next_state = CMP;
                end
            end
            // PEs run until the collector reports back
            CMP: begin
                if (all_finish) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // One word per cycle while configuring
    assign fifo_pop = (state == CFG) && !fifo_empty;

    // Any state but IDLE counts as a run
    assign busy = (state != IDLE);

    // ====================
    // Word decode
    // ====================
    always_comb begin
        cmd_d.valid = fifo_pop;
        cmd_d.kind  = fifo_out.setup.kind;
        // Kind bit picks the view
        if (fifo_out.setup.kind == SETUP) begin
            cmd_d.pe_id   = fifo_out.setup.pe_id;
            cmd_d.payload = fifo_out.setup.count;
        end else begin
            cmd_d.pe_id   = fifo_out.seed.pe_id;
            cmd_d.payload = fifo_out.seed.seed;
        end
    end

    // ====================
    // Registers
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= IDLE;
            pe_cmd <= '0;
            go     <= 1'b0;
        end else begin
            state  <= next_state;
            // Command lands at the PEs one cycle after the pop
            pe_cmd <= cmd_d;
            // High in the first CMP cycle only
            go     <= (state == CFG) && fifo_empty;
        end
    end

    // Last command must settle before the PEs start
    a_go_no_cmd : assert property (@(posedge clk) disable iff (!rst_n) !(go && pe_cmd.valid))
        else $error("ccu: go issued together with a valid command");

    // Collector only finishes a run this FSM started
    a_finish_in_cmp : assert property (@(posedge clk) disable iff (!rst_n)
        all_finish |-> (state == CMP))
        else $error("ccu: all_finish outside CMP");

endmodule

/* logic/pe_block.sv */
// One PE; result is seed*count mod 2**CCU_ACC_W and commands must not arrive while running
`timescale 1ns/1ns
`include "ccu_defines.svh"

module pe_block #(
    parameter int PE_INDEX = 0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  ccu_pe_pkg::pe_cmd_t     pe_cmd,
    input  logic                    go,
    output logic                    done,
    output logic [`CCU_ACC_W-1:0]   value
);
    import ccu_cfg_pkg::*;

    // Own address as a PE id
    localparam logic [`CCU_PE_ID_W-1:0] MY_ID = PE_INDEX[`CCU_PE_ID_W-1:0];

    logic [CFG_PAYLOAD_W-1:0] count;
    logic [CFG_PAYLOAD_W-1:0] seed;
    // Cycles left to accumulate
    logic [CFG_PAYLOAD_W-1:0] remaining;
    logic [`CCU_ACC_W-1:0]    acc;
    logic                     running;
    logic                     hit;

    // Command addressed to this PE
    assign hit = pe_cmd.valid && (pe_cmd.pe_id == MY_ID);

    // ====================
    // Config registers
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
            seed  <= '0;
        end else if (hit) begin
            // Later word overwrites the earlier one
            if (pe_cmd.kind == SETUP) begin
                count <= pe_cmd.payload;
            end else begin
                seed <= pe_cmd.payload;
            end
        end
    end

    // ====================
    // Accumulation
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running   <= 1'b0;
            remaining <= '0;
            acc       <= '0;
        end else if (go) begin
            // Zero count finishes right away
            running   <= (count != '0);
            remaining <= count;
            acc       <= '0;
        end else if (running) begin
            acc       <= acc + `CCU_ACC_W'(seed);
            remaining <= remaining - 1'b1;
            // Last add happens this cycle
            if (remaining == CFG_PAYLOAD_W'(1)) begin
                running <= 1'b0;
            end
        end
    end

    assign done  = !running;
    assign value = acc;

    // Controller must not reconfigure a PE mid-run
    a_no_cmd_running : assert property (@(posedge clk) disable iff (!rst_n) running |-> !hit)
        else $error("pe_block %0d: command while running", PE_INDEX);

endmodule

/* logic/finish_collector.sv */
// Armed by go; reads PEs out in ascending order and relies on done and values holding steady
`timescale 1ns/1ns
`include "ccu_defines.svh"

module finish_collector (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        go,
    input  logic [`CCU_NUM_PE-1:0]      done,
    input  logic [`CCU_ACC_W-1:0]       values [`CCU_NUM_PE],
    output logic                        result_val,
    output ccu_pe_pkg::pe_result_t      result,
    output logic                        all_finish
);
    localparam int LAST = `CCU_NUM_PE - 1;

    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        SEND,
        FIN
    } state_e;

    state_e                   state;
    logic [`CCU_PE_ID_W-1:0]  idx;

    // ====================
    // Sequencer
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            idx   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (go) begin
                        state <= WAIT;
                    end
                end
                // Every PE reports done
                WAIT: begin
                    if (&done) begin
                        state <= SEND;
                        idx   <= '0;
                    end
                end
                // One result per cycle
                SEND: begin
                    idx <= idx + 1'b1;
                    if (idx == LAST[`CCU_PE_ID_W-1:0]) begin
                        state <= FIN;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Outputs follow the state directly
    assign result_val   = (state == SEND);
    assign result.pe_id = idx;
    assign result.value = values[idx];
    assign all_finish   = (state == FIN);

    // Values must not move during readout
    a_done_stable : assert property (@(posedge clk) disable iff (!rst_n)
        (state == SEND) |-> &done)
        else $error("finish_collector: PE left done during readout");

endmodule

/* logic/ccu_top.sv */
// Top level; cfg_rdy is a plain level and the result stream has no back-pressure
`timescale 1ns/1ns
`include "ccu_defines.svh"

module ccu_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cfg_push,
    input  ccu_cfg_pkg::cfg_word_u  cfg_word,
    output logic                    cfg_rdy,
    input  logic                    start,
    output logic                    busy,
    output logic                    result_val,
    output ccu_pe_pkg::pe_result_t  result
);
    import ccu_cfg_pkg::*;
    import ccu_pe_pkg::*;

    // FIFO to controller
    cfg_word_u fifo_out;
    logic      fifo_pop;
    logic      fifo_empty;
    logic      fifo_full;

    // Controller to PEs
    pe_cmd_t   pe_cmd;
    logic      go;

    // PEs to collector
    logic [`CCU_NUM_PE-1:0] pe_done;
    logic [`CCU_ACC_W-1:0]  pe_value [`CCU_NUM_PE];
    logic                   all_finish;

    assign cfg_rdy = !fifo_full;

    // ====================
    // Config path
    // ====================
    cfg_fifo u_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (cfg_push),
        .pop      (fifo_pop),
        .data_in  (cfg_word),
        .data_out (fifo_out),
        .empty    (fifo_empty),
        .full     (fifo_full)
    );

    ccu u_ccu (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .fifo_empty (fifo_empty),
        .fifo_out   (fifo_out),
        .fifo_pop   (fifo_pop),
        .pe_cmd     (pe_cmd),
        .go         (go),
        .all_finish (all_finish),
        .busy       (busy)
    );

    // ====================
    // PE array
    // ====================
    for (genvar i = 0; i < `CCU_NUM_PE; i++) begin : g_pe
        pe_block #(
            .PE_INDEX (i)
        ) u_pe (
            .clk    (clk),
            .rst_n  (rst_n),
            .pe_cmd (pe_cmd),
            .go     (go),
            .done   (pe_done[i]),
            .value  (pe_value[i])
        );
    end

    // Readout in PE order
    finish_collector u_collector (
        .clk        (clk),
        .rst_n      (rst_n),
        .go         (go),
        .done       (pe_done),
        .values     (pe_value),
        .result_val (result_val),
        .result     (result),
        .all_finish (all_finish)
    );

endmodule

/* testbench/ccu_tb.sv */
// Needs --timing and --assert; random counts stay below 1024 so each run fits the cycle budget
`timescale 1ns/1ns
`include "ccu_defines.svh"

module ccu_tb;
    import ccu_cfg_pkg::*;
    import ccu_pe_pkg::*;

    // ====================
    // Limits
    // ====================
    localparam int FIFO_DEPTH     = 1 << `CCU_FIFO_AW;
    localparam int MAX_COUNT      = 1024;
    localparam int MAX_SEED       = 1 << CFG_PAYLOAD_W;
    // Pops, longest count, readout and margin
    localparam int RUN_CYCLES     = 1100;
    localparam int NUM_RUNS       = 5;
    // Reset, pushes and idle gaps
    localparam int SETUP_CYCLES   = 500;
    localparam int TIMEOUT_CYCLES = NUM_RUNS * RUN_CYCLES + SETUP_CYCLES;

    logic       clk;
    logic       rst_n;
    logic       cfg_push;
    cfg_word_u  cfg_word;
    logic       cfg_rdy;
    logic       start;
    logic       busy;
    logic       result_val;
    pe_result_t result;

    string test_name = "reset";
    int    cycle_count = 0;

    // Reference model of FIFO, FSM drain and PE registers
    cfg_word_u                  fifo_model [$];
    int                         model_fill;
    logic                       draining;
    logic [CFG_PAYLOAD_W-1:0]   model_count [`CCU_NUM_PE];
    logic [CFG_PAYLOAD_W-1:0]   model_seed  [`CCU_NUM_PE];
    logic [`CCU_ACC_W-1:0]      exp_value   [`CCU_NUM_PE];
    logic [`CCU_PE_ID_W-1:0]    next_id;
    int                         run_strobes;

    ccu_top u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_push   (cfg_push),
        .cfg_word   (cfg_word),
        .cfg_rdy    (cfg_rdy),
        .start      (start),
        .busy       (busy),
        .result_val (result_val),
        .result     (result)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ====================
    // Failure reporting
    // ====================
    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic report_mismatch(string what, logic [31:0] expected, logic [31:0] actual);
        report_failure($sformatf("ERROR %s: %s expected 0x%0h actual 0x%0h",
            test_name, what, expected, actual));
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            report_failure($sformatf("Timeout in %s after %0d cycles", test_name, cycle_count));
        end
    end

    // ====================
    // Reference model
    // ====================
    // Accumulated value wraps at the result width
    function automatic logic [`CCU_ACC_W-1:0] product_mod(logic [CFG_PAYLOAD_W-1:0] count,
                                                         logic [CFG_PAYLOAD_W-1:0] seed);
        logic [31:0] p;
        p = 32'(count) * 32'(seed);
        return p[`CCU_ACC_W-1:0];
    endfunction

    always @(posedge clk or negedge rst_n) begin : model_update
        cfg_word_u               w;
        logic [`CCU_PE_ID_W-1:0] id;
        if (!rst_n) begin
            fifo_model.delete();
            draining    = 1'b0;
            model_fill  = 0;
            next_id     = '0;
            run_strobes = 0;
            for (int i = 0; i < `CCU_NUM_PE; i++) begin
                model_count[i] = '0;
                model_seed[i]  = '0;
                exp_value[i]   = '0;
            end
        end else begin
            // One pop per cycle in CFG until the FIFO is empty
            if (busy && draining) begin
                if (fifo_model.size() == 0) begin
                    draining = 1'b0;
                end else begin
                    w  = fifo_model.pop_front();
                    id = w.setup.pe_id;
                    if (w.setup.kind == SETUP) begin
                        model_count[id] = w.setup.count;
                    end else begin
                        model_seed[id] = w.seed.seed;
                    end
                    exp_value[id] = product_mod(model_count[id], model_seed[id]);
                end
            end
            // Push only lands while there is room
            if (cfg_push && cfg_rdy) begin
                fifo_model.push_back(cfg_word);
            end
            if (result_val) begin
                next_id     = next_id + 1'b1;
                run_strobes = run_strobes + 1;
            end
            if (start && !busy) begin
                draining    = 1'b1;
                run_strobes = 0;
            end
            model_fill = fifo_model.size();
        end
    end

    // ====================
    // Checks
    // ====================
    a_result_value : assert property (@(posedge clk) disable iff (!rst_n)
        result_val |-> (result.value == exp_value[result.pe_id]))
        else report_mismatch("result value", 32'($sampled(exp_value[result.pe_id])),
            32'($sampled(result.value)));

    a_result_order : assert property (@(posedge clk) disable iff (!rst_n)
        result_val |-> (result.pe_id == next_id))
        else report_mismatch("result index", 32'($sampled(next_id)), 32'($sampled(result.pe_id)));

    a_rdy_level : assert property (@(posedge clk) disable iff (!rst_n)
        cfg_rdy == (model_fill != FIFO_DEPTH))
        else report_mismatch("cfg_rdy", 32'($sampled(model_fill) != FIFO_DEPTH),
            32'($sampled(cfg_rdy)));

    a_run_length : assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> (run_strobes == `CCU_NUM_PE))
        else report_mismatch("strobes per run", 32'(`CCU_NUM_PE), 32'($sampled(run_strobes)));

    a_strobe_in_run : assert property (@(posedge clk) disable iff (!rst_n)
        result_val |-> busy)
        else report_failure($sformatf("%s: result strobe while busy is low", test_name));

    a_run_needs_start : assert property (@(posedge clk) disable iff (!rst_n)
        $rose(busy) |-> $past(start))
        else report_failure($sformatf("%s: run began without a start pulse", test_name));

    // ====================
    // Stimulus helpers
    // ====================
    function automatic cfg_word_u make_word(cfg_kind_e kind, int id, int payload);
        cfg_word_u w;
        if (kind == SETUP) begin
            w.setup.kind  = SETUP;
            w.setup.pe_id = `CCU_PE_ID_W'(id);
            w.setup.count = CFG_PAYLOAD_W'(payload);
        end else begin
            w.seed.kind  = SEED;
            w.seed.pe_id = `CCU_PE_ID_W'(id);
            w.seed.seed  = CFG_PAYLOAD_W'(payload);
        end
        return w;
    endfunction

    // Random target from min_id up with short counts
    function automatic cfg_word_u random_word(int min_id);
        int        id;
        int        payload;
        cfg_kind_e kind;
        id   = min_id + int'($urandom % (`CCU_NUM_PE - min_id));
        kind = ($urandom % 2 == 0) ? SETUP : SEED;
        if (kind == SETUP) begin
            payload = int'($urandom % MAX_COUNT);
        end else begin
            payload = int'($urandom % MAX_SEED);
        end
        return make_word(kind, id, payload);
    endfunction

    // Optionally hold off until the FIFO has room
    task automatic push_word(cfg_word_u w, bit wait_rdy);
        @(negedge clk);
        while (wait_rdy && !cfg_rdy) begin
            cfg_push = 1'b0;
            @(negedge clk);
        end
        cfg_push = 1'b1;
        cfg_word = w;
    endtask

    task automatic release_push();
        @(negedge clk);
        cfg_push = 1'b0;
    endtask

    task automatic pulse_start();
        @(negedge clk);
        cfg_push = 1'b0;
        start    = 1'b1;
        @(negedge clk);
        start    = 1'b0;
    endtask

    task automatic wait_run_end();
        while (!busy) @(negedge clk);
        while (busy) @(negedge clk);
        repeat (3) @(negedge clk);
    endtask

    // ====================
    // Test sequence
    // ====================
    initial begin
        void'($urandom(10163));
        rst_n    = 1'b0;
        cfg_push = 1'b0;
        cfg_word = '0;
        start    = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Nothing queued and every PE still at zero
        test_name = "empty_run";
        pulse_start();
        wait_run_end();

        // Counts fill the FIFO and seeds follow while it drains
        test_name = "full_random";
        for (int i = 0; i < `CCU_NUM_PE; i++) begin
            push_word(make_word(SETUP, i, int'($urandom % MAX_COUNT)), 1'b1);
        end
        pulse_start();
        for (int i = 0; i < `CCU_NUM_PE; i++) begin
            push_word(make_word(SEED, i, int'($urandom % MAX_SEED)), 1'b1);
        end
        release_push();
        wait_run_end();

        // Later word for the same register wins
        test_name = "override";
        push_word(make_word(SETUP, 5, 700), 1'b1);
        push_word(make_word(SETUP, 5, 3), 1'b1);
        push_word(make_word(SEED, 5, 2000), 1'b1);
        push_word(make_word(SEED, 5, 1234), 1'b1);
        push_word(make_word(SEED, 12, 77), 1'b1);
        push_word(make_word(SETUP, 12, 0), 1'b1);
        push_word(make_word(SETUP, 12, 9), 1'b1);
        release_push();
        pulse_start();
        wait_run_end();

        // 17th word hits a full FIFO and is lost
        test_name = "fifo_full";
        push_word(make_word(SETUP, 0, 7), 1'b1);
        push_word(make_word(SEED, 0, 100), 1'b1);
        for (int i = 0; i < FIFO_DEPTH - 2; i++) begin
            push_word(random_word(1), 1'b1);
        end
        push_word(make_word(SEED, 0, 1999), 1'b0);
        release_push();
        pulse_start();
        wait_run_end();

        // Extra starts during CFG and readout
        test_name = "start_while_busy";
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            push_word(random_word(0), 1'b1);
        end
        release_push();
        pulse_start();
        repeat (4) @(negedge clk);
        pulse_start();
        while (!result_val) @(negedge clk);
        pulse_start();
        wait_run_end();
        repeat (20) @(negedge clk);

        $display("All tests passed");
        $finish;
    end

endmodule

/* project.f */
+incdir+logic
logic/ccu_cfg_pkg.sv
logic/ccu_pe_pkg.sv
logic/cfg_fifo.sv
logic/ccu.sv
logic/pe_block.sv
logic/finish_collector.sv
logic/ccu_top.sv
testbench/ccu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then decide pass or fail from the simulation log
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module ccu_tb -f project.f -o ccu_sim \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/ccu_sim > sim.log 2>&1
cat sim.log
grep -q "Some tests failed" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "All tests passed" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
